//--- Makefile
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dram_top -f list.f

run: build
	./obj_dir/Vtb_dram_top 2>&1 | tee $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -qF "*** TEST PASSED ***" $(LOG) || (echo "Simulation did not finish"; exit 1)

lint:
	verilator --lint-only -Wall --timing --top-module tb_dram_top -f list.f

clean:
	rm -rf obj_dir $(LOG)

//--- design/credit_fifo.sv
`timescale 1ns/1ps

module credit_fifo #(
  parameter type payload_t = logic
) (
  input  logic     mem_ui_clk,
  input  logic     mem_ui_rst,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     not_empty,
  output logic     full,
  output logic     credit
);

  payload_t            mem [dram_pkg::fifo_depth];
  dram_pkg::fifo_ptr_t wr_ptr;
  dram_pkg::fifo_ptr_t rd_ptr;
  dram_pkg::fifo_cnt_t count;
  logic                do_push;
  logic                do_pop;

  assign not_empty = (count != '0);
  assign full      = (count == dram_pkg::fifo_full_cnt);
  assign do_push   = push && !full;
  assign do_pop    = pop && not_empty;
  assign pop_data  = mem[rd_ptr];

  always_ff @(posedge mem_ui_clk) begin
    if (!mem_ui_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      // One credit goes back for every entry that leaves.
      credit <= do_pop;
      if (do_push) begin
        wr_ptr <= (wr_ptr == dram_pkg::fifo_last) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == dram_pkg::fifo_last) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge mem_ui_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

//--- design/dram_bridge.sv
`timescale 1ns/1ps

module dram_bridge (
  input  logic               mem_ui_clk,
  input  logic               mem_ui_rst,
  input  dram_pkg::mem_req_t req,
  input  logic               req_avail,
  output logic               req_pop,
  output dram_pkg::mem_rsp_t rsp,
  output logic               rsp_push,
  input  logic               rsp_full,
  mig_app_if.bridge          app
);

  dram_pkg::bridge_state_t state;
  dram_pkg::mem_req_t      cur;
  logic                    is_wr;
  logic                    rd_done;
  logic [dram_pkg::data_w-1:0] rd_half;

  assign is_wr   = (cur.wstrb != '0);
  assign rd_done = app.rd_data_valid && app.rd_data_end;

  // Take a new request only once the core is calibrated and a response slot is free.
  assign req_pop = (state == dram_pkg::idle) && req_avail && app.calib_complete
                   && !rsp_full;

  //////////////////////////////
  // Response path.
  assign rd_half = cur.addr[3] ? app.rd_data[dram_pkg::app_data_w-1:dram_pkg::data_w]
                               : app.rd_data[dram_pkg::data_w-1:0];

  assign rsp.write = is_wr;
  assign rsp.rdata = is_wr ? '0 : rd_half;

  // Writes answer on command acceptance, reads on the last beat.
  always_comb begin
    rsp_push = 1'b0;
    case (state)
      dram_pkg::set_cmd: rsp_push = app.rdy && is_wr;
      dram_pkg::wait_rd: rsp_push = rd_done;
      default:           rsp_push = 1'b0;
    endcase
  end

  //////////////////////////////
  // Control FSM.
  always_ff @(posedge mem_ui_clk) begin
    if (!mem_ui_rst) begin
      state        <= dram_pkg::idle;
      app.en       <= 1'b0;
      app.wdf_wren <= 1'b0;
      app.wdf_end  <= 1'b0;
    end else begin
      case (state)
        dram_pkg::idle: begin
          if (req_pop) begin
            state <= dram_pkg::preset;
          end
        end
        dram_pkg::preset: begin
          if (is_wr) begin
            state        <= dram_pkg::send_data;
            app.wdf_wren <= 1'b1;
            app.wdf_end  <= 1'b1;
          end else begin
            state  <= dram_pkg::set_cmd;
            app.en <= 1'b1;
          end
        end
        dram_pkg::send_data: begin
          // Data beat goes in first, then the write command.
          if (app.wdf_rdy) begin
            state        <= dram_pkg::set_cmd;
            app.wdf_wren <= 1'b0;
            app.wdf_end  <= 1'b0;
            app.en       <= 1'b1;
          end
        end
        dram_pkg::set_cmd: begin
          if (app.rdy) begin
            app.en <= 1'b0;
            state  <= is_wr ? dram_pkg::idle : dram_pkg::wait_rd;
          end
        end
        dram_pkg::wait_rd: begin
          if (rd_done) begin
            state <= dram_pkg::idle;
          end
        end
        default: state <= dram_pkg::idle;
      endcase
    end
  end

  //////////////////////////////
  // Request and controller payload.
  always_ff @(posedge mem_ui_clk) begin
    if (req_pop) begin
      cur <= req;
    end
    if (state == dram_pkg::preset) begin
      app.addr     <= {cur.addr[dram_pkg::addr_w-1:4], 4'b0000};
      app.cmd      <= is_wr ? dram_pkg::cmd_wr : dram_pkg::cmd_rd;
      app.wdf_data <= {(dram_pkg::app_data_w / dram_pkg::data_w){cur.wdata}};
      // Strobed bytes enabled in the selected half, the other half masked off.
      if (cur.addr[3]) begin
        app.wdf_mask <= {~cur.wstrb, {dram_pkg::strb_w{1'b1}}};
      end else begin
        app.wdf_mask <= {{dram_pkg::strb_w{1'b1}}, ~cur.wstrb};
      end
    end
  end

endmodule

//--- design/dram_pkg.sv
package dram_pkg;

  //////////////////////////////
  // Widths.
  localparam int addr_w     = 27;
  localparam int data_w     = 64;
  localparam int app_data_w = 128;
  localparam int strb_w     = 8;

  //////////////////////////////
  // Queue sizing.
  localparam int req_depth  = 4;
  localparam int rsp_depth  = 4;
  localparam int fifo_depth = (req_depth > rsp_depth) ? req_depth : rsp_depth;
  localparam int fifo_ptr_w = $clog2(fifo_depth);
  localparam int credit_w   = 8;

  typedef logic [fifo_ptr_w-1:0] fifo_ptr_t;
  typedef logic [fifo_ptr_w:0]   fifo_cnt_t;
  typedef logic [credit_w-1:0]   credit_cnt_t;

  localparam fifo_ptr_t fifo_last     = fifo_ptr_t'(fifo_depth - 1);
  localparam fifo_cnt_t fifo_full_cnt = fifo_cnt_t'(fifo_depth);

  // Controller command codes.
  localparam logic [2:0] cmd_wr = 3'd0;
  localparam logic [2:0] cmd_rd = 3'd1;

  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] wstrb;
  } mem_req_t;

  typedef struct packed {
    logic [data_w-1:0] rdata;
    logic              write;
  } mem_rsp_t;

  typedef enum logic [2:0] {idle, preset, send_data, set_cmd, wait_rd} bridge_state_t;

endpackage

//--- design/dram_top.sv
`timescale 1ns/1ps

module dram_top (
  input  logic                              mem_ui_clk,
  input  logic                              mem_ui_rst,
  // Client side.
  input  logic                              req_valid,
  input  logic [dram_pkg::addr_w-1:0]       req_addr,
  input  logic [dram_pkg::data_w-1:0]       req_wdata,
  input  logic [dram_pkg::strb_w-1:0]       req_wstrb,
  output logic                              req_credit,
  input  logic                              rsp_credit,
  output logic                              rsp_valid,
  output logic [dram_pkg::data_w-1:0]       rsp_rdata,
  output logic                              rsp_write,
  // Controller user interface.
  output logic [dram_pkg::addr_w-1:0]       app_addr,
  output logic [2:0]                        app_cmd,
  output logic                              app_en,
  output logic [dram_pkg::app_data_w-1:0]   app_wdf_data,
  output logic                              app_wdf_end,
  output logic [dram_pkg::app_data_w/8-1:0] app_wdf_mask,
  output logic                              app_wdf_wren,
  input  logic                              app_rdy,
  input  logic                              app_wdf_rdy,
  input  logic [dram_pkg::app_data_w-1:0]   app_rd_data,
  input  logic                              app_rd_data_valid,
  input  logic                              app_rd_data_end,
  input  logic                              calib_complete
);

  dram_pkg::mem_req_t req_in;
  dram_pkg::mem_req_t req_q;
  dram_pkg::mem_rsp_t rsp_d;
  dram_pkg::mem_rsp_t rsp_q;
  logic               req_avail;
  logic               req_pop;
  logic               rsp_push;
  logic               rsp_full;
  logic               rsp_avail;
  logic               rsp_pop;

  mig_app_if app ();

  assign req_in = '{addr: req_addr, wdata: req_wdata, wstrb: req_wstrb};

  assign app_addr          = app.addr;
  assign app_cmd           = app.cmd;
  assign app_en            = app.en;
  assign app_wdf_data      = app.wdf_data;
  assign app_wdf_end       = app.wdf_end;
  assign app_wdf_mask      = app.wdf_mask;
  assign app_wdf_wren      = app.wdf_wren;
  assign app.rdy           = app_rdy;
  assign app.wdf_rdy       = app_wdf_rdy;
  assign app.rd_data       = app_rd_data;
  assign app.rd_data_valid = app_rd_data_valid;
  assign app.rd_data_end   = app_rd_data_end;
  assign app.calib_complete = calib_complete;

  assign rsp_valid = rsp_pop;
  assign rsp_rdata = rsp_q.rdata;
  assign rsp_write = rsp_q.write;

  credit_fifo #(.payload_t(dram_pkg::mem_req_t)) u_req_q (
    .mem_ui_clk (mem_ui_clk), .mem_ui_rst (mem_ui_rst),
    .push (req_valid), .push_data (req_in), .pop (req_pop), .pop_data (req_q),
    .not_empty (req_avail), .full (), .credit (req_credit)
  );

  credit_fifo #(.payload_t(dram_pkg::mem_rsp_t)) u_rsp_q (
    .mem_ui_clk (mem_ui_clk), .mem_ui_rst (mem_ui_rst),
    .push (rsp_push), .push_data (rsp_d), .pop (rsp_pop), .pop_data (rsp_q),
    .not_empty (rsp_avail), .full (rsp_full), .credit ()
  );

  dram_bridge u_bridge (
    .mem_ui_clk (mem_ui_clk), .mem_ui_rst (mem_ui_rst),
    .req (req_q), .req_avail (req_avail), .req_pop (req_pop),
    .rsp (rsp_d), .rsp_push (rsp_push), .rsp_full (rsp_full), .app (app.bridge)
  );

  rsp_credit_tx u_rsp_tx (
    .mem_ui_clk (mem_ui_clk), .mem_ui_rst (mem_ui_rst),
    .rsp_credit (rsp_credit), .not_empty (rsp_avail), .pop (rsp_pop)
  );

endmodule

//--- design/mig_app_if.sv
`timescale 1ns/1ps

interface mig_app_if;

  logic [dram_pkg::addr_w-1:0]       addr;
  logic [2:0]                        cmd;
  logic                              en;
  logic [dram_pkg::app_data_w-1:0]   wdf_data;
  logic                              wdf_end;
  logic [dram_pkg::app_data_w/8-1:0] wdf_mask;
  logic                              wdf_wren;

  // Driven by the controller core.
  logic                              rdy;
  logic                              wdf_rdy;
  logic [dram_pkg::app_data_w-1:0]   rd_data;
  logic                              rd_data_valid;
  logic                              rd_data_end;
  logic                              calib_complete;

  modport bridge (
    output addr, cmd, en, wdf_data, wdf_end, wdf_mask, wdf_wren,
    input  rdy, wdf_rdy, rd_data, rd_data_valid, rd_data_end, calib_complete
  );

  modport ctrl (
    input  addr, cmd, en, wdf_data, wdf_end, wdf_mask, wdf_wren,
    output rdy, wdf_rdy, rd_data, rd_data_valid, rd_data_end, calib_complete
  );

endinterface

//--- design/rsp_credit_tx.sv
`timescale 1ns/1ps

module rsp_credit_tx (
  input  logic mem_ui_clk,
  input  logic mem_ui_rst,
  input  logic rsp_credit,
  input  logic not_empty,
  output logic pop
);

  dram_pkg::credit_cnt_t count;
  logic                  have_credit;

  assign have_credit = (count != '0);

  // Send whenever a response waits and the client has room for it.
  assign pop = not_empty && have_credit;

  //////////////////////////////
  // Credit counter.
  always_ff @(posedge mem_ui_clk) begin
    if (!mem_ui_rst) begin
      count <= '0;
    end else begin
      case ({rsp_credit, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

//--- list.f
design/dram_pkg.sv
design/mig_app_if.sv
design/credit_fifo.sv
design/rsp_credit_tx.sv
design/dram_bridge.sv
design/dram_top.sv
tb/dram_properties.sv
tb/tb_dram_top.sv

//--- tb/dram_properties.sv
`timescale 1ns/1ps

module dram_properties (
  input logic       mem_ui_clk,
  input logic       mem_ui_rst,
  input logic       app_en,
  input logic       app_rdy,
  input logic [2:0] app_cmd,
  input logic       app_wdf_wren,
  input logic       req_valid,
  input logic       req_full,
  input logic       rsp_credit,
  input logic       rsp_valid
);

  logic [7:0] granted;

  // Response credits granted by the client and not yet used.
  always_ff @(posedge mem_ui_clk) begin
    if (!mem_ui_rst) begin
      granted <= '0;
    end else begin
      granted <= granted + 8'(rsp_credit) - 8'(rsp_valid);
    end
  end

  // Command stays up until the controller takes it.
  en_held: assert property (@(posedge mem_ui_clk) disable iff (!mem_ui_rst)
    app_en && !app_rdy |=> app_en)
    else $error("app_en dropped before app_rdy");

  // A write command follows its data beat.
  wdata_first: assert property (@(posedge mem_ui_clk) disable iff (!mem_ui_rst)
    $rose(app_en) && app_cmd == dram_pkg::cmd_wr |-> $past(app_wdf_wren))
    else $error("write command issued without a preceding data beat");

  no_push_full: assert property (@(posedge mem_ui_clk) disable iff (!mem_ui_rst)
    req_valid |-> !req_full)
    else $error("req_valid while the request queue is full");

  rsp_has_credit: assert property (@(posedge mem_ui_clk) disable iff (!mem_ui_rst)
    rsp_valid |-> granted != 8'd0)
    else $error("rsp_valid without a response credit");

endmodule

bind dram_top dram_properties props (
  .mem_ui_clk   (mem_ui_clk),
  .mem_ui_rst   (mem_ui_rst),
  .app_en       (app_en),
  .app_rdy      (app_rdy),
  .app_cmd      (app_cmd),
  .app_wdf_wren (app_wdf_wren),
  .req_valid    (req_valid),
  .req_full     (u_req_q.full),
  .rsp_credit   (rsp_credit),
  .rsp_valid    (rsp_valid)
);

//--- tb/tb_dram_top.sv
`timescale 1ns/1ps

module tb_dram_top;

  localparam int total_req = 312;

  logic         mem_ui_clk = 1'b0;
  logic         mem_ui_rst = 1'b0;
  logic         req_valid = 1'b0;
  logic [26:0]  req_addr = '0;
  logic [63:0]  req_wdata = '0;
  logic [7:0]   req_wstrb = '0;
  logic         rsp_credit = 1'b0;
  logic         app_rdy = 1'b0;
  logic         app_wdf_rdy = 1'b0;
  logic [127:0] app_rd_data = '0;
  logic         app_rd_data_valid = 1'b0;
  logic         app_rd_data_end = 1'b0;
  logic         calib_complete = 1'b0;
  logic         req_credit;
  logic         rsp_valid;
  logic [63:0]  rsp_rdata;
  logic         rsp_write;
  logic [26:0]  app_addr;
  logic [2:0]   app_cmd;
  logic         app_en;
  logic [127:0] app_wdf_data;
  logic         app_wdf_end;
  logic [15:0]  app_wdf_mask;
  logic         app_wdf_wren;

  integer             seed = 32'h2f89f270;
  logic [7:0]         ctrl_mem [int];
  logic [7:0]         ref_mem [int];
  dram_pkg::mem_req_t req_log [$];
  logic [64:0]        exp_rsp [$];
  logic [127:0]       beat_data;
  logic [15:0]        beat_mask;
  logic [127:0]       rd_word;
  int cyc = 0;
  int rd_cnt = 0;
  int stall_left = 0;
  int credits = dram_pkg::req_depth;
  int grants = 0;
  int to_send = 0;
  int to_grant = 0;
  int n_req = 0;
  int n_req_credit = 0;
  int n_rsp = 0;
  int errors = 0;
  bit stall = 1'b0;
  bit hold_rsp = 1'b0;

  dram_top DUT (.*);

  always #50 mem_ui_clk = ~mem_ui_clk;

  // Unwritten bytes read back a pattern built from the whole address.
  function automatic logic [7:0] fill_byte(input int a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ {5'b00000, a[26:24]};
  endfunction

  function automatic logic [7:0] ctrl_byte(input int a);
    return ctrl_mem.exists(a) ? ctrl_mem[a] : fill_byte(a);
  endfunction

  function automatic logic [7:0] ref_byte(input int a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_byte(a);
  endfunction

  task automatic mismatch(input string name, input logic [127:0] exp_v,
                          input logic [127:0] act_v);
    errors = errors + 1;
    $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
  endtask

  task automatic complain(input string msg);
    errors = errors + 1;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  always @(negedge mem_ui_clk) begin
    int r;
    int base;
    logic [26:0] line;
    logic [15:0] exp_mask;
    logic [64:0] exp_word;
    dram_pkg::mem_req_t cur;
    cyc = cyc + 1;
    mem_ui_rst     = (cyc >= 16);
    calib_complete = (cyc >= 24);

    //////////////////////////////
    // Controller model.
    r = $random(seed);
    app_rd_data_valid = 1'b0;
    app_rd_data_end   = 1'b0;
    if (rd_cnt != 0) begin
      rd_cnt = rd_cnt - 1;
      if (rd_cnt == 0) begin
        app_rd_data       = rd_word;
        app_rd_data_valid = 1'b1;
        app_rd_data_end   = 1'b1;
      end
    end
    if (stall_left != 0) begin
      stall_left = stall_left - 1;
    end else if (stall && r[7:5] == 3'd0) begin
      stall_left = 8 + int'(r[12:8]);
    end
    app_rdy     = (stall_left == 0) && (r[1:0] != 2'd0);
    app_wdf_rdy = (stall_left == 0) && (r[3:2] != 2'd0);
    if (app_wdf_wren && app_wdf_rdy) begin
      beat_data = app_wdf_data;
      beat_mask = app_wdf_mask;
      // Every write is a single beat, so each beat is the last one.
      if (app_wdf_end !== 1'b1)
        mismatch("app_wdf_end", 128'(1'b1), 128'(app_wdf_end));
    end
    if (app_en && app_rdy) begin
      if (req_log.size() == 0) begin
        complain("controller took a command with no request outstanding");
      end else begin
        cur  = req_log.pop_front();
        line = {cur.addr[26:4], 4'b0000};
        if (app_addr !== line)
          mismatch("app_addr", 128'(line), 128'(app_addr));
        if (cur.wstrb != 8'h00) begin
          for (int j = 0; j < 16; j++) begin
            exp_mask[j] = !((j[3] == cur.addr[3]) && cur.wstrb[j[2:0]]);
          end
          if (app_cmd !== dram_pkg::cmd_wr)
            mismatch("app_cmd", 128'(dram_pkg::cmd_wr), 128'(app_cmd));
          if (beat_mask !== exp_mask)
            mismatch("app_wdf_mask", 128'(exp_mask), 128'(beat_mask));
          if (beat_data !== {cur.wdata, cur.wdata})
            mismatch("app_wdf_data", {cur.wdata, cur.wdata}, beat_data);
          for (int j = 0; j < 16; j++) begin
            if (!beat_mask[j])
              ctrl_mem[int'(line) + j] = beat_data[8*j +: 8];
          end
        end else begin
          if (app_cmd !== dram_pkg::cmd_rd)
            mismatch("app_cmd", 128'(dram_pkg::cmd_rd), 128'(app_cmd));
          for (int j = 0; j < 16; j++) begin
            rd_word[8*j +: 8] = ctrl_byte(int'(line) + j);
          end
          rd_cnt = 1 + int'(r[15:13]);
        end
      end
    end

    //////////////////////////////
    // Client and response checker.
    req_valid  = 1'b0;
    rsp_credit = 1'b0;
    if (mem_ui_rst) begin
      if (req_credit) begin
        credits      = credits + 1;
        n_req_credit = n_req_credit + 1;
      end
      if (rsp_valid) begin
        n_rsp = n_rsp + 1;
        if (grants == 0)
          complain("rsp_valid without a granted response credit");
        else
          grants = grants - 1;
        if (exp_rsp.size() == 0) begin
          complain("response with no request outstanding");
        end else begin
          exp_word = exp_rsp.pop_front();
          if (rsp_write !== exp_word[64])
            mismatch("rsp_write", 128'(exp_word[64]), 128'(rsp_write));
          if (rsp_rdata !== exp_word[63:0])
            mismatch("rsp_rdata", 128'(exp_word[63:0]), 128'(rsp_rdata));
        end
      end
      r = $random(seed);
      if (to_grant != 0) begin
        rsp_credit = 1'b1;
        to_grant   = to_grant - 1;
        grants     = grants + 1;
      end else if (!hold_rsp && grants < 4 && r[0]) begin
        rsp_credit = 1'b1;
        grants     = grants + 1;
      end
      if (to_send != 0 && credits != 0 && r[1]) begin
        req_valid = 1'b1;
        req_addr  = 27'h1a30000 | 27'(r[15:8]);
        req_wdata = {$random(seed), $random(seed)};
        req_wstrb = r[2] ? r[23:16] : 8'h00;
        req_log.push_back('{addr: req_addr, wdata: req_wdata, wstrb: req_wstrb});
        // Reference image follows the strobes in request order.
        base = int'({req_addr[26:4], 4'b0000}) + (req_addr[3] ? 8 : 0);
        if (req_wstrb != 8'h00) begin
          for (int i = 0; i < 8; i++) begin
            if (req_wstrb[i])
              ref_mem[base + i] = req_wdata[8*i +: 8];
          end
          exp_rsp.push_back({1'b1, 64'd0});
        end else begin
          exp_word[64] = 1'b0;
          for (int i = 0; i < 8; i++) begin
            exp_word[8*i +: 8] = ref_byte(base + i);
          end
          exp_rsp.push_back(exp_word);
        end
        credits = credits - 1;
        to_send = to_send - 1;
        n_req   = n_req + 1;
      end
    end
  end

  task automatic wait_idle();
    while (to_send != 0 || exp_rsp.size() != 0)
      @(posedge mem_ui_clk);
    repeat (4) @(posedge mem_ui_clk);
    if (n_req_credit != n_req)
      mismatch("req_credit pulses", 128'(n_req), 128'(n_req_credit));
    if (credits != dram_pkg::req_depth)
      mismatch("request credits", 128'(dram_pkg::req_depth), 128'(credits));
  endtask

  task automatic run_test(input string name, input int n, input bit stall_on);
    int err0;
    err0    = errors;
    stall   = stall_on;
    to_send = n;
    wait_idle();
    stall = 1'b0;
    $display("test %s done: %0d requests, %0d errors", name, n, errors - err0);
  endtask

  task automatic hold_test();
    int err0;
    int left;
    int seen;
    err0     = errors;
    hold_rsp = 1'b1;
    left     = grants;
    seen     = n_rsp;
    to_send  = 8 + left;
    while (to_send != 0)
      @(posedge mem_ui_clk);
    repeat (100) @(posedge mem_ui_clk);
    if (n_rsp - seen != left)
      mismatch("rsp_valid count while held", 128'(left), 128'(n_rsp - seen));
    seen     = n_rsp;
    to_grant = 3;
    repeat (50) @(posedge mem_ui_clk);
    if (n_rsp - seen != 3)
      mismatch("rsp_valid count after grant", 128'(3), 128'(n_rsp - seen));
    hold_rsp = 1'b0;
    wait_idle();
    $display("test rsp_hold done: %0d requests, %0d errors", 8 + left, errors - err0);
  endtask

  initial begin
    while (!mem_ui_rst || !calib_complete)
      @(posedge mem_ui_clk);
    run_test("write_read", 150, 1'b0);
    run_test("backpressure", 150, 1'b1);
    hold_test();
    $display("summary: 3 tests, %0d requests, %0d responses, %0d errors",
             n_req, n_rsp, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    #((400 * total_req + 200) * 100);
    $display("Watchdog expired before all requests completed");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
